// ==== hw/bubble_geom_pkg.sv ====
package bubble_geom_pkg;

    // Each output channel holds one bit per bubble position
    localparam int BUF_AW  = 13;   // Word address per channel buffer
    localparam int BIT_AW  = 14;   // Loader bit address, bit 0 picks the channel
    localparam int PAGE_AW = 10;   // Cycle number bits used inside a user page

    // Word map of each channel buffer
    //   0    .. 1327  bootloader bits
    //   1328 .. 1911  bad loop table
    //   1912 .. 4038  CRC area and filler
    //   4039 .. 4105  sync pattern
    //   4106 .. 7167  unused
    //   7168 .. 7751  user page
    //   8191          empty propagation line
    localparam int USER_BASE  = 7168;  // First word of the user page
    localparam int SYNC_FIRST = 4039;  // Zeros on D0 start here
    localparam int SYNC_ONE   = 4104;  // Single one on D0
    localparam int SYNC_LAST  = 4105;  // Don't care word, written as zero
    localparam int EMPTY_LINE = 8191;  // Read while no access runs

endpackage

// ==== hw/bubble_ctrl_pkg.sv ====
package bubble_ctrl_pkg;

    // Access codes as the bubble host sends them
    typedef enum logic [2:0] {
        ACC_NONE = 3'b000,
        ACC_BOOT = 3'b110,   // Bootloop read
        ACC_USER = 3'b111    // Single user page read
    } acc_type_e;

    localparam int BOOT_CYCLES = 4106;  // Ticks in a boot access
    localparam int USER_CYCLES = 584;   // Ticks in a user access
    localparam int BOUT_DIV    = 4;     // mclk cycles per output tick
    localparam int BOUT_DIV_W  = $clog2(BOUT_DIV);
    localparam int CYC_W       = 13;    // Bubble cycle number width

    typedef struct packed {
        acc_type_e acc;
    } acc_req_t;

    typedef struct packed {
        logic             active;  // Access in progress
        logic             tick;    // Launch one output bit
        acc_type_e        acc;     // Latched access type
        logic [CYC_W-1:0] num;     // Bubble cycle number of this tick
    } cycle_t;

    typedef struct packed {
        logic [10:0] addr;  // Byte address
        logic [7:0]  data;
    } load_byte_t;

    typedef struct packed {
        logic [bubble_geom_pkg::BIT_AW-1:0] addr;  // {word, channel}
        logic                               data;
    } buf_wr_t;

endpackage

// ==== hw/bubble_cycle_gen.sv ====
module bubble_cycle_gen
(
    input  logic                      mclk,
    input  logic                      rst_n,
    input  logic                      acc_start,
    input  bubble_ctrl_pkg::acc_req_t acc_req,
    output bubble_ctrl_pkg::cycle_t   cyc
);
    import bubble_ctrl_pkg::*;

    logic                  active_q;  // Access running
    acc_type_e             acc_q;     // Type of the running access
    logic [BOUT_DIV_W-1:0] div_q;     // Tick divider
    logic [CYC_W-1:0]      num_q;     // Current bubble cycle
    logic [CYC_W-1:0]      len;       // Ticks in this access
    logic                  tick;
    logic                  start_ok;

    assign len = (acc_q == ACC_BOOT) ? CYC_W'(BOOT_CYCLES) : CYC_W'(USER_CYCLES);
    assign tick = active_q && (div_q == BOUT_DIV_W'(BOUT_DIV - 1));

    // Only a real access type starts anything, and only from idle
    assign start_ok = acc_start && !active_q &&
                      ((acc_req.acc == ACC_BOOT) || (acc_req.acc == ACC_USER));

    always_ff @(posedge mclk)
    begin
        if (!rst_n)
        begin
            active_q <= 1'b0;
            acc_q    <= ACC_NONE;
            div_q    <= '0;
            num_q    <= '0;
        end
        else if (start_ok)
        begin
            active_q <= 1'b1;
            acc_q    <= acc_req.acc;
            div_q    <= '0;  // First tick BOUT_DIV cycles after the strobe
            num_q    <= '0;
        end
        else if (tick)
        begin
            div_q <= '0;
            if (num_q == len - CYC_W'(1))  // Last bit launched
            begin
                active_q <= 1'b0;
                acc_q    <= ACC_NONE;
                num_q    <= '0;
            end
            else
            begin
                num_q <= num_q + CYC_W'(1);
            end
        end
        else if (active_q)
        begin
            div_q <= div_q + BOUT_DIV_W'(1);
        end
    end

    assign cyc = '{active: active_q, tick: tick, acc: acc_q, num: num_q};

    // Counter stays inside the access length
    a_num_in_range: assert property (@(posedge mclk) disable iff (!rst_n)
        active_q |-> (num_q < len));

endmodule

// ==== hw/sync_pattern_writer.sv ====
module sync_pattern_writer
(
    input  logic                      mclk,
    input  logic                      rst_n,
    output logic                      req,
    output bubble_ctrl_pkg::buf_wr_t  wr,
    input  logic                      gnt,
    output logic                      init_done
);
    import bubble_geom_pkg::*;

    logic [BUF_AW-1:0] word_q;  // Word being written
    logic              ch_q;    // 0 for D0, 1 for D1
    logic              one_bit;

    assign req = !init_done;  // Requests until the empty line is in

    // Single one on D0 at SYNC_ONE, zeros everywhere else
    assign one_bit = (word_q == BUF_AW'(SYNC_ONE)) && !ch_q;
    assign wr = '{addr: {word_q, ch_q}, data: one_bit};

    always_ff @(posedge mclk)
    begin
        if (!rst_n)
        begin
            word_q    <= BUF_AW'(SYNC_FIRST);
            ch_q      <= 1'b0;
            init_done <= 1'b0;
        end
        else if (req && gnt)
        begin
            ch_q <= ~ch_q;
            if (ch_q)  // Both channels of this word done
            begin
                if (word_q == BUF_AW'(EMPTY_LINE))
                begin
                    init_done <= 1'b1;
                end
                else if (word_q == BUF_AW'(SYNC_LAST))
                begin
                    word_q <= BUF_AW'(EMPTY_LINE);  // Jump to propagation line
                end
                else
                begin
                    word_q <= word_q + BUF_AW'(1);
                end
            end
        end
    end

endmodule

// ==== hw/page_loader.sv ====
module page_loader
(
    input  logic                       mclk,
    input  logic                       rst_n,
    input  logic                       ld_valid,
    input  bubble_ctrl_pkg::load_byte_t ld,
    output logic                       req,
    output bubble_ctrl_pkg::buf_wr_t   wr,
    input  logic                       gnt,
    output logic                       busy,
    output logic                       overrun
);
    import bubble_ctrl_pkg::*;

    load_byte_t byte_q;  // Address and bits still to go
    logic [2:0] idx_q;   // Bit index within the byte

    assign req = busy;
    assign wr = '{addr: {byte_q.addr, idx_q}, data: byte_q.data[0]};  // LSB first

    always_ff @(posedge mclk)
    begin
        if (!rst_n)
        begin
            busy    <= 1'b0;
            overrun <= 1'b0;
            idx_q   <= '0;
        end
        else if (busy)
        begin
            if (ld_valid)
            begin
                overrun <= 1'b1;  // Byte dropped, sticky until reset
            end
            if (gnt)
            begin
                idx_q <= idx_q + 3'd1;
                if (idx_q == 3'd7)
                begin
                    busy <= 1'b0;
                end
            end
        end
        else if (ld_valid)
        begin
            busy  <= 1'b1;
            idx_q <= '0;
        end
    end

    // Shift register for the byte payload
    always_ff @(posedge mclk)
    begin
        if (!busy && ld_valid)
        begin
            byte_q <= ld;
        end
        else if (busy && gnt)
        begin
            byte_q.data <= byte_q.data >> 1;
        end
    end

endmodule

// ==== hw/buffer_write_arbiter.sv ====
module buffer_write_arbiter
(
    input  logic                     mclk,
    input  logic                     rst_n,
    input  logic                     pat_req,
    input  bubble_ctrl_pkg::buf_wr_t pat_wr,
    output logic                     pat_gnt,
    input  logic                     ld_req,
    input  bubble_ctrl_pkg::buf_wr_t ld_wr,
    output logic                     ld_gnt,
    output logic                     we,
    output bubble_ctrl_pkg::buf_wr_t wr
);

    // Pattern writer wins so loader bits land after init
    assign pat_gnt = pat_req;
    assign ld_gnt  = ld_req && !pat_req;

    always_ff @(posedge mclk)
    begin
        if (!rst_n)
        begin
            we <= 1'b0;
        end
        else
        begin
            we <= pat_gnt || ld_gnt;  // Buffer write one cycle after grant
        end
    end

    always_ff @(posedge mclk)
    begin
        if (pat_gnt)
        begin
            wr <= pat_wr;
        end
        else if (ld_gnt)
        begin
            wr <= ld_wr;
        end
    end

    a_one_grant: assert property (@(posedge mclk) disable iff (!rst_n)
        !(pat_gnt && ld_gnt));

endmodule

// ==== hw/bubble_out_buffer.sv ====
module bubble_out_buffer
(
    input  logic                     mclk,
    input  logic                     we,
    input  bubble_ctrl_pkg::buf_wr_t wr,
    input  bubble_ctrl_pkg::cycle_t  cyc,
    output logic                     dout0,
    output logic                     dout1,
    output logic                     dout_valid,
    input  logic                     rst_n
);
    import bubble_geom_pkg::*;
    import bubble_ctrl_pkg::*;

    logic              d0_mem [2**BUF_AW];  // Even channel bits
    logic              d1_mem [2**BUF_AW];  // Odd channel bits
    logic [BUF_AW-1:0] wr_word;
    logic [1:0]        wr_en;    // {D1, D0}
    logic [BUF_AW-1:0] rd_addr;

    // Write decode, bit 0 of the bit address picks the channel
    assign wr_word = wr.addr[BIT_AW-1:1];
    assign wr_en   = we ? (wr.addr[0] ? 2'b10 : 2'b01) : 2'b00;

    // Read decode from the bubble cycle number
    always_comb
    begin
        rd_addr = BUF_AW'(EMPTY_LINE);  // Idle lines read zero
        if (cyc.active)
        begin
            case (cyc.acc)
                ACC_BOOT:
                begin
                    rd_addr = cyc.num;  // Whole loop in order
                end
                ACC_USER:
                begin
                    rd_addr = BUF_AW'(USER_BASE) + BUF_AW'(cyc.num[PAGE_AW-1:0]);
                end
                default:
                begin
                    rd_addr = BUF_AW'(EMPTY_LINE);
                end
            endcase
        end
    end

    always_ff @(posedge mclk)
    begin
        if (wr_en[0])
        begin
            d0_mem[wr_word] <= wr.data;
        end
    end

    always_ff @(posedge mclk)
    begin
        if (wr_en[1])
        begin
            d1_mem[wr_word] <= wr.data;
        end
    end

    // Output lines are active low, idle high
    always_ff @(posedge mclk)
    begin
        if (!rst_n)
        begin
            dout0      <= 1'b1;
            dout1      <= 1'b1;
            dout_valid <= 1'b0;
        end
        else
        begin
            dout_valid <= cyc.tick;
            if (cyc.tick)
            begin
                dout0 <= ~d0_mem[rd_addr];
                dout1 <= ~d1_mem[rd_addr];
            end
        end
    end

    a_tick_in_access: assert property (@(posedge mclk) disable iff (!rst_n)
        cyc.tick |-> cyc.active);

endmodule

// ==== hw/bubble_emu_top.sv ====
module bubble_emu_top
(
    input  logic                        mclk,
    input  logic                        rst_n,
    input  logic                        acc_start,
    input  bubble_ctrl_pkg::acc_req_t   acc_req,
    input  logic                        ld_valid,
    input  bubble_ctrl_pkg::load_byte_t ld,
    output logic                        dout0,
    output logic                        dout1,
    output logic                        dout_valid,
    output logic                        busy,
    output logic                        init_done,
    output logic                        overrun
);
    import bubble_ctrl_pkg::*;

    cycle_t   cyc;       // Tick and cycle number to the buffer
    logic     pat_req;
    logic     pat_gnt;
    buf_wr_t  pat_wr;
    logic     ld_req;
    logic     ld_gnt;
    buf_wr_t  ld_wr;
    logic     buf_we;
    buf_wr_t  buf_wr;    // Arbitrated write into the buffer

    bubble_cycle_gen u_cycle_gen (.mclk(mclk), .rst_n(rst_n), .acc_start(acc_start),
                                  .acc_req(acc_req), .cyc(cyc));

    sync_pattern_writer u_pattern (.mclk(mclk), .rst_n(rst_n), .req(pat_req),
                                   .wr(pat_wr), .gnt(pat_gnt), .init_done(init_done));

    page_loader u_loader (.mclk(mclk), .rst_n(rst_n), .ld_valid(ld_valid), .ld(ld),
                          .req(ld_req), .wr(ld_wr), .gnt(ld_gnt), .busy(busy),
                          .overrun(overrun));

    buffer_write_arbiter u_arbiter (.mclk(mclk), .rst_n(rst_n), .pat_req(pat_req),
                                    .pat_wr(pat_wr), .pat_gnt(pat_gnt), .ld_req(ld_req),
                                    .ld_wr(ld_wr), .ld_gnt(ld_gnt), .we(buf_we),
                                    .wr(buf_wr));

    bubble_out_buffer u_buffer (.mclk(mclk), .we(buf_we), .wr(buf_wr), .cyc(cyc),
                                .dout0(dout0), .dout1(dout1), .dout_valid(dout_valid),
                                .rst_n(rst_n));

endmodule

// ==== tests/tb_bubble_emu.sv ====
module tb_bubble_emu;
    timeunit 1ns;
    timeprecision 1ps;
    import bubble_geom_pkg::*;
    import bubble_ctrl_pkg::*;

    localparam int PAGE_BYTES = USER_CYCLES * 2 / 8;  // Bytes behind one user page
    localparam int USER_BYTE  = USER_BASE * 2 / 8;    // First byte address of the page

    logic        mclk = 1'b0;
    logic        rst_n;
    logic        acc_start;
    acc_req_t    acc_req;
    logic        ld_valid;
    load_byte_t  ld;
    logic        dout0, dout1, dout_valid, busy, init_done, overrun;

    bit          model [int];  // Expected buffer bit per bit address
    logic [1:0]  cap [int];    // {dout1, dout0} per tick index
    logic [7:0]  page [$];     // LCG bytes of the user page
    byte         rec_kind [$];
    int          rec_a [$];
    int          rec_b [$];
    int          rec_c [$];
    int          strobe_cnt = 0;
    int          err_cnt = 0;
    int          test_cnt = 0;
    int          fail_cnt = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;
    logic [31:0] lcg_state = 32'd49041;

    bubble_emu_top u_bubble_emu_top (.*);

    always #50 mclk = ~mclk;  // 100 ns period

    // Bit pairs captured on the falling edge
    always @(negedge mclk)
    begin
        if (dout_valid)
        begin
            cap[strobe_cnt] = {dout1, dout0};
            strobe_cnt = strobe_cnt + 1;
        end
    end

    always @(posedge mclk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit)
        begin
            $display("Run stopped after %0d cycles without reaching the end", cycle_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [7:0] lcg_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];  // Middle bits of the state
    endfunction

    task automatic compare(input string what, input int got, input int exp);
        if (got !== exp)
        begin
            $display("ERROR at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        test_cnt++;
        if (err_cnt == err_before)
        begin
            $display("test %s: ok", name);
        end
        else
        begin
            fail_cnt++;
            $display("test %s: failed with %0d errors", name, err_cnt - err_before);
        end
    endtask

    // Bit i of a byte sits at bit address byte * 8 + i
    task automatic store_byte(input int addr, input logic [7:0] data);
        for (int i = 0; i < 8; i++)
        begin
            model[addr * 8 + i] = 1'(data >> i);
        end
    endtask

    task automatic wait_loader_idle();
        do
        begin
            @(negedge mclk);
        end
        while (busy);
    endtask

    task automatic send_byte(input int addr, input logic [7:0] data);
        @(posedge mclk);
        ld_valid <= 1'b1;
        ld       <= '{addr: 11'(addr), data: data};
        @(posedge mclk);
        ld_valid <= 1'b0;
        wait_loader_idle();
        store_byte(addr, data);
    endtask

    // Starts an access and collects its bit pairs
    // A boot request fires at strobe restart_at when it is not negative
    task automatic run_access(input logic [2:0] acc, input int len, input int restart_at);
        int waited;
        waited = 0;
        strobe_cnt = 0;
        @(posedge mclk);
        acc_start <= 1'b1;
        acc_req   <= '{acc: acc_type_e'(acc)};
        @(posedge mclk);
        acc_start <= 1'b0;
        acc_req   <= '{acc: ACC_BOOT};
        while (strobe_cnt < len && waited < len * BOUT_DIV + 8)
        begin
            acc_start <= (strobe_cnt == restart_at);
            @(posedge mclk);
            waited++;
        end
        acc_start <= 1'b0;
        repeat (4 * BOUT_DIV) @(posedge mclk);  // Room for any stray strobe
    endtask

    // Boot tick t reads word t and user tick t reads USER_BASE plus t mod 1024
    // Lines carry the stored bits inverted
    task automatic check_page(input logic [2:0] acc, input int first, input int last);
        int word;
        int b;
        for (int t = first; t < last; t++)
        begin
            word = (acc == ACC_BOOT) ? t : USER_BASE + t % 1024;
            for (int ch = 0; ch < 2; ch++)
            begin
                b = word * 2 + ch;
                if (model.exists(b))
                begin
                    compare($sformatf("tick %0d dout%0d", t, ch),
                            (int'(cap[t]) >> ch) & 1, int'(!model[b]));
                end
            end
        end
    endtask

    initial
    begin
        int         fd;
        int         n;
        int         a;
        int         b;
        int         c;
        int         err0;
        int         len;
        int         n_bytes;
        string      line;
        logic [2:0] acc;
        logic [7:0] x_data;

        rst_n     = 1'b0;
        acc_start = 1'b0;
        acc_req   = '{acc: ACC_NONE};
        ld_valid  = 1'b0;
        ld        = '0;
        n_bytes   = 0;

        fd = $fopen("tests/bubble_input.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open tests/bubble_input.txt for reading");
            $display("TESTS FAILED");
            $finish;
        end
        while ($fgets(line, fd) > 0)
        begin
            a = 0;
            b = 0;
            c = 0;
            n = 0;
            if (line.len() > 1 && line.getc(0) != "#")
            begin
                if (line.getc(0) == "W")
                begin
                    n = $sscanf(line, "W %h %h", a, b);
                    n_bytes++;
                end
                else if (line.getc(0) == "A")
                begin
                    n = $sscanf(line, "A %d", a);
                end
                else
                begin
                    n = $sscanf(line, "E %d %d %d", a, b, c);
                end
                rec_kind.push_back(line.getc(0));
                rec_a.push_back(a);
                rec_b.push_back(b);
                rec_c.push_back(c);
            end
        end
        $fclose(fd);
        cycle_limit = (BOOT_CYCLES + 2 * USER_CYCLES) * BOUT_DIV
                      + 16 * (n_bytes + PAGE_BYTES + 2) + 500;

        repeat (4) @(posedge mclk);
        rst_n <= 1'b1;
        err0 = err_cnt;
        @(negedge mclk);
        compare("busy after reset", int'(busy), 0);
        compare("overrun after reset", int'(overrun), 0);
        compare("init_done after reset", int'(init_done), 0);
        n = 0;
        while (!init_done && n < 200)  // Pattern writer needs 136 grants
        begin
            compare("dout0 before init", int'(dout0), 1);
            compare("dout1 before init", int'(dout1), 1);
            compare("dout_valid before init", int'(dout_valid), 0);
            @(negedge mclk);
            n++;
        end
        if (!init_done)
        begin
            $display("init_done did not rise within 200 cycles of reset");
            err_cnt++;
        end
        end_test("1 reset and init", err0);

        // File records run in order
        for (int i = 0; i < rec_kind.size(); i++)
        begin
            if (rec_kind[i] == "W")
            begin
                send_byte(rec_a[i], 8'(rec_b[i]));
            end
            else if (rec_kind[i] == "A")
            begin
                acc = 3'(rec_a[i]);
                len = (acc == ACC_BOOT) ? BOOT_CYCLES : USER_CYCLES;
                err0 = err_cnt;
                run_access(acc, len, -1);
                for (int j = i + 1; j < rec_kind.size() && rec_kind[j] == "E"; j++)
                begin
                    compare($sformatf("tick %0d dout1", rec_a[j]), int'(cap[rec_a[j]][1]),
                            rec_b[j]);
                    compare($sformatf("tick %0d dout0", rec_a[j]), int'(cap[rec_a[j]][0]),
                            rec_c[j]);
                end
                end_test("2 file expected bits", err0);
                err0 = err_cnt;
                compare("strobe count", strobe_cnt, len);
                check_page(acc, 0, len);
                end_test("3 written boot bytes", err0);
            end
        end

        err0 = err_cnt;
        for (int i = 0; i < PAGE_BYTES; i++)
        begin
            page.push_back(lcg_byte());
            send_byte(USER_BYTE + i, page[i]);
        end
        run_access(ACC_USER, USER_CYCLES, -1);
        compare("user strobe count", strobe_cnt, USER_CYCLES);
        check_page(ACC_USER, 0, USER_CYCLES);
        end_test("4 user page", err0);

        err0 = err_cnt;
        @(negedge mclk);
        compare("overrun before second byte", int'(overrun), 0);
        x_data = lcg_byte();
        @(posedge mclk);
        ld_valid <= 1'b1;
        ld       <= '{addr: 11'(USER_BYTE), data: x_data};
        @(posedge mclk);
        ld       <= '{addr: 11'(USER_BYTE + 1), data: ~page[1]};  // Lands while busy
        @(posedge mclk);
        ld_valid <= 1'b0;
        wait_loader_idle();
        store_byte(USER_BYTE, x_data);
        compare("overrun after second byte", int'(overrun), 1);
        run_access(ACC_USER, USER_CYCLES, 100);
        check_page(ACC_USER, 4, 8);  // Words of the dropped byte
        end_test("5 overrun", err0);

        err0 = err_cnt;
        compare("strobe count with restart", strobe_cnt, USER_CYCLES);
        check_page(ACC_USER, 0, USER_CYCLES);
        end_test("6 restart ignored", err0);

        $display("%0d tests run, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/bubble_input.txt ====
# W byte_addr data (hex) | A access type (6 boot, 7 user) | E tick dout1 dout0 (decimal)
# E records check the strobes of the access started by the A record above them
W 000 a5
W 001 3c
W 064 0f
W 14b e7
A 6
E 0 1 0
E 1 1 0
E 2 0 1
E 3 0 1
E 4 1 1
E 5 0 0
E 4039 1 1
E 4040 1 1
E 4072 1 1
E 4103 1 1
E 4104 1 0
E 4105 1 1

// ==== bubble_emu_top.f ====
hw/bubble_geom_pkg.sv
hw/bubble_ctrl_pkg.sv
hw/bubble_cycle_gen.sv
hw/sync_pattern_writer.sv
hw/page_loader.sv
hw/buffer_write_arbiter.sv
hw/bubble_out_buffer.sv
hw/bubble_emu_top.sv
tests/tb_bubble_emu.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, look for the pass line in $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_bubble_emu \
		-f bubble_emu_top.f -o sim_bubble_emu
	./obj_dir/sim_bubble_emu | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
